// File: compile.f
rtl/isaPkg.sv
rtl/datapathPkg.sv
rtl/decodeIf.sv
rtl/aluOpDecoder.sv
rtl/controlSequencer.sv
rtl/riscvController.sv
tests/controllerTb.sv

// File: rtl/aluOpDecoder.sv
// Combinational decoder from instruction word to ALU code, B source, immediate and load info
`timescale 1ns/1ps
`default_nettype none

module aluOpDecoder (
    input  isaPkg::instr_t instr,  // Held instruction word
    decodeIf.decoder       dec     // Decoded control toward the FSM
);

    isaPkg::opcode_t opcode;
    isaPkg::funct3_t funct3;
    isaPkg::funct7_t funct7;       // Same bits as imm12[11:5]
    isaPkg::imm12_t  imm12;
    logic            shiftOp;      // sll, srl or sra form
    logic            altForm;      // funct7 is the alternate value

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign imm12   = instr[31:20];
    assign shiftOp = (funct3 == isaPkg::f3Sll) || (funct3 == isaPkg::f3SrlSra);
    assign altForm = (funct7 == isaPkg::funct7Alt);

    // Shared funct3 mapping for register and immediate ALU ops
    function automatic datapathPkg::aluSel_t aluFromFunct3(
        input isaPkg::funct3_t f3,
        input logic            alt   // sub / sra select
    );
        datapathPkg::aluSel_t sel;
        case (f3)
            isaPkg::f3AddSub: sel = alt ? datapathPkg::aluSub : datapathPkg::aluAdd;
            isaPkg::f3Sll:    sel = datapathPkg::aluSll;
            isaPkg::f3Slt:    sel = datapathPkg::aluSlt;
            isaPkg::f3Sltu:   sel = datapathPkg::aluSltu;
            isaPkg::f3Xor:    sel = datapathPkg::aluXor;
            isaPkg::f3SrlSra: sel = alt ? datapathPkg::aluSra : datapathPkg::aluSrl;
            isaPkg::f3Or:     sel = datapathPkg::aluOr;
            default:          sel = datapathPkg::aluAnd;
        endcase
        return sel;
    endfunction

    always_comb
    begin
        dec.aluSel       = datapathPkg::aluAdd;  // Also the load address add
        dec.bSel         = datapathPkg::bSelImm;
        dec.immValue     = datapathPkg::word_t'(signed'(imm12));  // Sign extend
        dec.isLoad       = 1'b0;
        dec.needsRs2     = 1'b0;
        dec.loadExtend   = datapathPkg::aluByteSigned;
        dec.extendNeeded = 1'b0;
        dec.legal        = 1'b0;

        case (opcode)
            isaPkg::opReg:
            begin
                dec.aluSel   = aluFromFunct3(funct3, altForm);
                dec.bSel     = datapathPkg::bSelBus;  // rs2 from the bus
                dec.needsRs2 = 1'b1;
                dec.legal    = (funct7 == isaPkg::funct7Base) || altForm;
            end
            isaPkg::opImm:
            begin
                // Alternate form only means sra here, addi stays add
                dec.aluSel = aluFromFunct3(funct3, altForm && (funct3 == isaPkg::f3SrlSra));
                if (shiftOp)
                begin
                    dec.immValue = datapathPkg::word_t'(imm12[datapathPkg::shamtWidth-1:0]);
                    dec.legal    = (funct7 == isaPkg::funct7Base) || altForm;
                end
                else
                begin
                    dec.legal = 1'b1;  // Any immediate is fine
                end
            end
            isaPkg::opLoad:
            begin
                dec.isLoad       = 1'b1;
                dec.extendNeeded = 1'b1;  // Cleared below for lw
                dec.legal        = 1'b1;
                case (funct3)
                    isaPkg::f3Lb:  dec.loadExtend = datapathPkg::aluByteSigned;
                    isaPkg::f3Lh:  dec.loadExtend = datapathPkg::aluHalfSigned;
                    isaPkg::f3Lbu: dec.loadExtend = datapathPkg::aluByteUnsigned;
                    isaPkg::f3Lhu: dec.loadExtend = datapathPkg::aluHalfUnsigned;
                    isaPkg::f3Lw:  dec.extendNeeded = 1'b0;  // Word taken from A as is
                    default:       dec.legal = 1'b0;         // funct3 3, 6, 7
                endcase
            end
            default:
            begin
                dec.legal = 1'b0;  // Stores, lui and the rest retire silently
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/controlSequencer.sv
// FSM stepping one instruction through register read, ALU, memory read and write-back
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  logic                 clk,
    input  logic                 reset,
    decodeIf.sequencer           dec,
    input  logic                 instrValid,
    output logic                 instrReady,
    input  datapathPkg::word_t   pcIn,
    output datapathPkg::word_t   pcOut,
    output logic                 regReq,      // Held until dataReady
    input  logic                 dataReady,
    output datapathPkg::muxSel_t aSel,
    output datapathPkg::muxSel_t bSel,
    output datapathPkg::muxSel_t oSel,
    output logic                 aEnable,
    output logic                 bEnable,
    output datapathPkg::word_t   immValue,
    output datapathPkg::aluSel_t aluSel,
    output logic                 aluStart,    // Held until aluComplete
    input  logic                 aluComplete,
    output logic                 memRead,     // Held until memAck
    input  logic                 memAck,
    output logic                 rdWrite      // One cycle per retired instruction
);

    typedef enum logic [2:0] {
        idle,
        readRegs,
        loadOperands,
        execute,
        memAccess,
        extendLoad,
        extendExecute,
        writeBack
    } state_t;

    state_t state;
    state_t nextState;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= idle;
            pcOut <= '0;
        end
        else
        begin
            state <= nextState;
            if (state == writeBack)
            begin
                pcOut <= pcIn + datapathPkg::word_t'(1);  // Advance on retire only
            end
        end
    end

    always_comb
    begin
        nextState = state;
        case (state)
            idle:
            begin
                if (instrValid)
                begin
                    nextState = readRegs;  // Word is latched on this edge
                end
            end
            readRegs:
            begin
                if (!dec.legal)
                begin
                    nextState = idle;  // Unsupported word, no write-back
                end
                else if (dataReady)
                begin
                    nextState = loadOperands;
                end
            end
            loadOperands:  nextState = execute;
            execute:
            begin
                if (aluComplete)
                begin
                    nextState = dec.isLoad ? memAccess : writeBack;
                end
            end
            memAccess:
            begin
                if (memAck)
                begin
                    nextState = extendLoad;
                end
            end
            // Memory word into A, then optional extension pass
            extendLoad:    nextState = dec.extendNeeded ? extendExecute : writeBack;
            extendExecute:
            begin
                if (aluComplete)
                begin
                    nextState = writeBack;
                end
            end
            default:       nextState = idle;  // writeBack
        endcase
    end

    assign instrReady = (state == idle);
    assign regReq     = (state == readRegs) && dec.legal;
    assign aEnable    = (state == loadOperands) || (state == extendLoad);  // One-cycle pulses
    assign bEnable    = (state == loadOperands);
    assign aSel       = aEnable ? datapathPkg::aSelBus : '0;
    assign bSel       = (state == idle) ? '0 : dec.bSel;  // Stable for the whole instruction
    assign immValue   = dec.immValue;
    assign aluStart   = (state == execute) || (state == extendExecute);
    assign memRead    = (state == memAccess);
    assign rdWrite    = (state == writeBack);

    // Second pass swaps in the extension code
    assign aluSel = (state == extendExecute) ? dec.loadExtend : dec.aluSel;

    // Word load writes A directly, everything else the ALU result
    assign oSel = ((state == writeBack) && dec.isLoad && !dec.extendNeeded)
                ? datapathPkg::oSelRegA : datapathPkg::oSelAlu;

endmodule

`default_nettype wire

// File: rtl/datapathPkg.sv
// Datapath word type, ALU operation codes and operand/output mux selects
`default_nettype none

package datapathPkg;

    localparam int wordWidth   = 32;
    localparam int aluSelWidth = 5;
    localparam int muxSelWidth = 2;

    typedef logic [wordWidth-1:0]   word_t;    // Data value, PC or immediate
    typedef logic [aluSelWidth-1:0] aluSel_t;  // ALU operation code
    typedef logic [muxSelWidth-1:0] muxSel_t;  // Operand or output mux select

    // Arithmetic and logic codes
    localparam aluSel_t aluAdd  = 5'b00000;
    localparam aluSel_t aluSub  = 5'b00001;
    localparam aluSel_t aluSll  = 5'b00100;
    localparam aluSel_t aluSrl  = 5'b00101;
    localparam aluSel_t aluSra  = 5'b01111;
    localparam aluSel_t aluSlt  = 5'b01110;
    localparam aluSel_t aluSltu = 5'b01101;
    localparam aluSel_t aluXor  = 5'b01010;
    localparam aluSel_t aluOr   = 5'b01011;
    localparam aluSel_t aluAnd  = 5'b01000;

    // Load extension codes, applied to operand A
    localparam aluSel_t aluByteSigned   = 5'b10000;
    localparam aluSel_t aluHalfSigned   = 5'b10001;
    localparam aluSel_t aluByteUnsigned = 5'b10010;
    localparam aluSel_t aluHalfUnsigned = 5'b10011;

    // Operand register input selects
    localparam muxSel_t aSelBus = 2'b01;  // A loads from the bus
    localparam muxSel_t bSelBus = 2'b01;  // B loads from the bus
    localparam muxSel_t bSelImm = 2'b10;  // B loads the immediate

    // Output mux selects
    localparam muxSel_t oSelAlu  = 2'b00;
    localparam muxSel_t oSelRegA = 2'b01;

    // Shift amount bits kept from a shift immediate
    localparam int shamtWidth = 5;

endpackage

`default_nettype wire

// File: rtl/decodeIf.sv
// Interface bundling decoded control from the instruction decoder to the FSM
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;

    datapathPkg::aluSel_t aluSel;        // Operation of the main ALU pass
    datapathPkg::muxSel_t bSel;          // B register source
    datapathPkg::word_t   immValue;      // Extended or masked immediate
    logic                 isLoad;        // Memory read after address add
    logic                 needsRs2;      // Second source register used
    datapathPkg::aluSel_t loadExtend;    // Extension code for sub-word loads
    logic                 extendNeeded;  // Low for word loads
    logic                 legal;         // Encoding is supported

    modport decoder (output aluSel, bSel, immValue, isLoad, needsRs2,
                     loadExtend, extendNeeded, legal);

    // needsRs2 is consumed at the top level, not by the FSM
    modport sequencer (input aluSel, bSel, immValue, isLoad,
                       loadExtend, extendNeeded, legal);

endinterface

`default_nettype wire

// File: rtl/isaPkg.sv
// Instruction field widths, field types, opcode values and funct codes
`default_nettype none

package isaPkg;

    // Field widths of the 32-bit encoding
    localparam int instrWidth   = 32;
    localparam int opcodeWidth  = 7;
    localparam int funct3Width  = 3;
    localparam int funct7Width  = 7;
    localparam int regAddrWidth = 5;
    localparam int imm12Width   = 12;

    typedef logic [instrWidth-1:0]   instr_t;    // Whole instruction word
    typedef logic [opcodeWidth-1:0]  opcode_t;   // Bits 6:0
    typedef logic [funct3Width-1:0]  funct3_t;   // Bits 14:12
    typedef logic [funct7Width-1:0]  funct7_t;   // Bits 31:25
    typedef logic [regAddrWidth-1:0] regAddr_t;  // rs1, rs2 or rd index
    typedef logic [imm12Width-1:0]   imm12_t;    // I-type immediate, bits 31:20

    // Opcodes kept by the controller
    localparam opcode_t opLoad = 7'd3;
    localparam opcode_t opImm  = 7'd19;
    localparam opcode_t opReg  = 7'd51;

    localparam funct7_t funct7Base = 7'b0000000;
    localparam funct7_t funct7Alt  = 7'b0100000;  // Picks sub and sra

    // ALU funct3 values, same for register and immediate forms
    localparam funct3_t f3AddSub = 3'b000;
    localparam funct3_t f3Sll    = 3'b001;
    localparam funct3_t f3Slt    = 3'b010;
    localparam funct3_t f3Sltu   = 3'b011;
    localparam funct3_t f3Xor    = 3'b100;
    localparam funct3_t f3SrlSra = 3'b101;
    localparam funct3_t f3Or     = 3'b110;
    localparam funct3_t f3And    = 3'b111;

    // Load widths
    localparam funct3_t f3Lb  = 3'b000;
    localparam funct3_t f3Lh  = 3'b001;
    localparam funct3_t f3Lw  = 3'b010;
    localparam funct3_t f3Lbu = 3'b100;
    localparam funct3_t f3Lhu = 3'b101;

endpackage

`default_nettype wire

// File: rtl/riscvController.sv
// Top-level instruction controller with instruction register, decoder and FSM
`timescale 1ns/1ps
`default_nettype none

module riscvController (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instrValid,
    input  isaPkg::instr_t        instr,
    output logic                  instrReady,
    input  datapathPkg::word_t    pcIn,
    output datapathPkg::word_t    pcOut,
    output logic                  regReq,
    input  logic                  dataReady,
    output isaPkg::regAddr_t      rs1Out,
    output isaPkg::regAddr_t      rs2Out,
    output datapathPkg::muxSel_t  aSel,
    output datapathPkg::muxSel_t  bSel,
    output datapathPkg::muxSel_t  oSel,
    output logic                  aEnable,
    output logic                  bEnable,
    output datapathPkg::word_t    immValue,
    output datapathPkg::aluSel_t  aluSel,
    output logic                  aluStart,
    input  logic                  aluComplete,
    output logic                  memRead,
    input  logic                  memAck,
    output isaPkg::regAddr_t      rdOut,
    output logic                  rdWrite
);

    isaPkg::instr_t instrReg;  // Instruction in flight

    decodeIf decBus ();

    // Capture on the valid/ready edge, held until retire
    always_ff @(posedge clk)
    begin
        if (instrValid && instrReady)
        begin
            instrReg <= instr;
        end
    end

    assign rs1Out = instrReg[19:15];
    assign rs2Out = decBus.needsRs2 ? instrReg[24:20] : '0;  // Immediate bits stay off the bus
    assign rdOut  = instrReg[11:7];

    aluOpDecoder uDecoder (
        .instr (instrReg),
        .dec   (decBus.decoder)
    );

    controlSequencer uSequencer (
        .clk         (clk),
        .reset       (reset),
        .dec         (decBus.sequencer),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .pcIn        (pcIn),
        .pcOut       (pcOut),
        .regReq      (regReq),
        .dataReady   (dataReady),
        .aSel        (aSel),
        .bSel        (bSel),
        .oSel        (oSel),
        .aEnable     (aEnable),
        .bEnable     (bEnable),
        .immValue    (immValue),
        .aluSel      (aluSel),
        .aluStart    (aluStart),
        .aluComplete (aluComplete),
        .memRead     (memRead),
        .memAck      (memAck),
        .rdWrite     (rdWrite)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f compile.f --top-module controllerTb -o controllerSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/controllerSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0

// File: tests/controllerTb.sv
// Directed testbench for riscvController with datapath responders, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module controllerTb;

    localparam int maxInstr       = 40;               // Upper bound on instructions issued
    localparam int cyclesPerInstr = 4 + 4 * 5;        // Fixed states plus four waits of 5
    localparam int timeoutCycles  = maxInstr * cyclesPerInstr;

    // ALU code expected for each funct3, indexed by funct3
    localparam datapathPkg::aluSel_t aluByFunct3 [8] = '{
        datapathPkg::aluAdd, datapathPkg::aluSll, datapathPkg::aluSlt, datapathPkg::aluSltu,
        datapathPkg::aluXor, datapathPkg::aluSrl, datapathPkg::aluOr,  datapathPkg::aluAnd
    };

    logic                 clk;
    logic                 reset;
    logic                 instrValid;
    isaPkg::instr_t       instr;
    logic                 instrReady;
    datapathPkg::word_t   pcIn;
    datapathPkg::word_t   pcOut;
    logic                 regReq;
    logic                 dataReady;
    isaPkg::regAddr_t     rs1Out;
    isaPkg::regAddr_t     rs2Out;
    datapathPkg::muxSel_t aSel;
    datapathPkg::muxSel_t bSel;
    datapathPkg::muxSel_t oSel;
    logic                 aEnable;
    logic                 bEnable;
    datapathPkg::word_t   immValue;
    datapathPkg::aluSel_t aluSel;
    logic                 aluStart;
    logic                 aluComplete;
    logic                 memRead;
    logic                 memAck;
    isaPkg::regAddr_t     rdOut;
    logic                 rdWrite;

    int cycleCount = 0;
    int delayFloor;  // Shortest responder delay
    int seedState;

    riscvController UUT (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
        .instrReady(instrReady), .pcIn(pcIn), .pcOut(pcOut), .regReq(regReq),
        .dataReady(dataReady), .rs1Out(rs1Out), .rs2Out(rs2Out), .aSel(aSel),
        .bSel(bSel), .oSel(oSel), .aEnable(aEnable), .bEnable(bEnable),
        .immValue(immValue), .aluSel(aluSel), .aluStart(aluStart),
        .aluComplete(aluComplete), .memRead(memRead), .memAck(memAck),
        .rdOut(rdOut), .rdWrite(rdWrite)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Run limit in clock cycles
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Timeout after %0d cycles, the controller stopped making progress",
                     cycleCount);
            $display("Test failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkAluSel(input string name, input datapathPkg::aluSel_t expected,
                               input datapathPkg::aluSel_t actual);
        if (actual !== expected)
        begin
            reportFail($sformatf("Fail at %0t: %s expected %b, got %b",
                                 $time, name, expected, actual));
        end
    endtask

    task automatic checkWord(input string name, input datapathPkg::word_t expected,
                             input datapathPkg::word_t actual);
        if (actual !== expected)
        begin
            reportFail($sformatf("Fail at %0t: %s expected %h, got %h",
                                 $time, name, expected, actual));
        end
    endtask

    task automatic checkRegAddr(input string name, input isaPkg::regAddr_t expected,
                                input isaPkg::regAddr_t actual);
        if (actual !== expected)
        begin
            reportFail($sformatf("Fail at %0t: %s expected %0d, got %0d",
                                 $time, name, expected, actual));
        end
    endtask

    task automatic checkSel(input string name, input datapathPkg::muxSel_t expected,
                            input datapathPkg::muxSel_t actual);
        if (actual !== expected)
        begin
            reportFail($sformatf("Fail at %0t: %s expected %b, got %b",
                                 $time, name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            reportFail($sformatf("Fail at %0t: %s expected %b, got %b",
                                 $time, name, expected, actual));
        end
    endtask

    function automatic isaPkg::regAddr_t randomReg();
        return isaPkg::regAddr_t'($urandom);
    endfunction

    function automatic datapathPkg::word_t signExtend12(input isaPkg::imm12_t imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic isaPkg::instr_t encodeR(input isaPkg::funct7_t f7,
                                               input isaPkg::funct3_t f3);
        return {f7, randomReg(), randomReg(), f3, randomReg(), isaPkg::opReg};
    endfunction

    function automatic isaPkg::instr_t encodeI(input isaPkg::imm12_t imm,
                                               input isaPkg::funct3_t f3,
                                               input isaPkg::opcode_t opcode);
        return {imm, randomReg(), f3, randomReg(), opcode};
    endfunction

    // Acknowledge a pending request after a random wait, for one cycle
    task automatic answerRequest(inout int delay, output logic ack);
        if (delay < 0)
        begin
            delay = $urandom_range(5, delayFloor);
        end
        if (delay == 0)
        begin
            ack   = 1'b1;
            delay = -1;
        end
        else
        begin
            ack = 1'b0;
            delay--;
        end
    endtask

    // Issue one instruction and follow it to retire or back to idle
    task automatic runInstr(
        input isaPkg::instr_t       word,
        input datapathPkg::aluSel_t expAlu,
        input datapathPkg::muxSel_t expBSel,
        input datapathPkg::word_t   expImm,
        input logic                 load,
        input datapathPkg::aluSel_t expExt,
        input logic                 extend,
        input logic                 legal
    );
        datapathPkg::word_t pcBefore;
        int                 delay;       // -1 while no ack is scheduled
        int                 aluPasses;
        int                 memPasses;
        int                 aPulses;
        int                 bPulses;
        int                 busyCycles;
        pcBefore   = pcOut;
        delay      = -1;
        aluPasses  = 0;
        memPasses  = 0;
        aPulses    = 0;
        bPulses    = 0;
        busyCycles = 0;
        checkBit("instrReady", 1'b1, instrReady);
        pcIn       = $urandom;
        instr      = word;
        instrValid = 1'b1;
        @(negedge clk);
        instrValid = 1'b0;
        instr      = '0;

        while (!instrReady && !rdWrite)
        begin
            busyCycles++;
            if (!legal)
            begin
                checkBit("regReq", 1'b0, regReq);  // Illegal word issues nothing
            end
            if (regReq)
            begin
                checkRegAddr("rs1Out", word[19:15], rs1Out);
                if (expBSel == datapathPkg::bSelBus)
                begin
                    checkRegAddr("rs2Out", word[24:20], rs2Out);
                end
                answerRequest(delay, dataReady);
            end
            if (aluStart)
            begin
                checkAluSel("aluSel", (aluPasses == 0) ? expAlu : expExt, aluSel);
                checkSel("bSel", expBSel, bSel);
                if (expBSel == datapathPkg::bSelImm)
                begin
                    checkWord("immValue", expImm, immValue);
                end
                answerRequest(delay, aluComplete);
                if (aluComplete)
                begin
                    aluPasses++;
                end
            end
            if (memRead)
            begin
                checkSel("oSel", datapathPkg::oSelAlu, oSel);  // Address from the ALU
                answerRequest(delay, memAck);
                if (memAck)
                begin
                    memPasses++;
                end
            end
            if (aEnable)
            begin
                checkSel("aSel", datapathPkg::aSelBus, aSel);  // A always loads from the bus
                aPulses++;
            end
            if (bEnable)
            begin
                bPulses++;
            end
            @(negedge clk);
            dataReady   = 1'b0;  // Acks last one cycle
            aluComplete = 1'b0;
            memAck      = 1'b0;
        end

        if (legal)
        begin
            checkBit("rdWrite", 1'b1, rdWrite);
            checkRegAddr("rdOut", word[11:7], rdOut);
            checkSel("oSel", (load && !extend) ? datapathPkg::oSelRegA : datapathPkg::oSelAlu,
                     oSel);
            checkWord("pcOut", pcBefore, pcOut);  // Not yet advanced
            if (aluPasses != ((load && extend) ? 2 : 1))
            begin
                reportFail($sformatf("Wrong number of ALU passes, saw %0d", aluPasses));
            end
            if (memPasses != (load ? 1 : 0) || bPulses != 1 || aPulses != (load ? 2 : 1))
            begin
                reportFail("Memory reads or operand enables did not match the instruction");
            end
            @(negedge clk);
            checkBit("rdWrite", 1'b0, rdWrite);
            checkBit("instrReady", 1'b1, instrReady);
            checkWord("pcOut", pcIn + 32'd1, pcOut);
        end
        else
        begin
            checkBit("rdWrite", 1'b0, rdWrite);
            checkBit("instrReady", 1'b1, instrReady);
            checkWord("pcOut", pcBefore, pcOut);
            if (busyCycles != 1)
            begin
                reportFail("Illegal instruction did not return to idle on the second edge");
            end
        end
    endtask

    task automatic runRegister(input isaPkg::funct7_t f7, input isaPkg::funct3_t f3,
                               input datapathPkg::aluSel_t expAlu);
        runInstr(encodeR(f7, f3), expAlu, datapathPkg::bSelBus, '0, 1'b0,
                 datapathPkg::aluAdd, 1'b0, 1'b1);
    endtask

    task automatic runImmediate(input isaPkg::imm12_t imm, input isaPkg::funct3_t f3);
        runInstr(encodeI(imm, f3, isaPkg::opImm), aluByFunct3[f3], datapathPkg::bSelImm,
                 signExtend12(imm), 1'b0, datapathPkg::aluAdd, 1'b0, 1'b1);
    endtask

    task automatic runLoad(input isaPkg::funct3_t f3, input datapathPkg::aluSel_t ext,
                           input logic extend);
        isaPkg::imm12_t imm;
        imm = isaPkg::imm12_t'($urandom);
        runInstr(encodeI(imm, f3, isaPkg::opLoad), datapathPkg::aluAdd, datapathPkg::bSelImm,
                 signExtend12(imm), 1'b1, ext, extend, 1'b1);
    endtask

    task automatic runIllegal(input isaPkg::instr_t word);
        runInstr(word, datapathPkg::aluAdd, datapathPkg::bSelBus, '0, 1'b0,
                 datapathPkg::aluAdd, 1'b0, 1'b0);
    endtask

    task automatic testResetState();
        checkBit("regReq", 1'b0, regReq);
        checkBit("aluStart", 1'b0, aluStart);
        checkBit("memRead", 1'b0, memRead);
        checkBit("rdWrite", 1'b0, rdWrite);
        checkBit("aEnable", 1'b0, aEnable);
        checkBit("bEnable", 1'b0, bEnable);
        checkWord("pcOut", '0, pcOut);
        checkBit("instrReady", 1'b1, instrReady);
    endtask

    task automatic testRegisterOps();
        for (int f = 0; f < 8; f++)
        begin
            runRegister(isaPkg::funct7Base, isaPkg::funct3_t'(f),
                        aluByFunct3[isaPkg::funct3_t'(f)]);
        end
        runRegister(isaPkg::funct7Alt, isaPkg::f3AddSub, datapathPkg::aluSub);
        runRegister(isaPkg::funct7Alt, isaPkg::f3SrlSra, datapathPkg::aluSra);
    endtask

    task automatic testImmediateOps();
        runImmediate(12'h7ff, isaPkg::f3AddSub);  // Largest positive
        runImmediate(12'h800, isaPkg::f3AddSub);  // Most negative
        runImmediate(12'h400, isaPkg::f3AddSub);  // Alt bits still mean add
        runImmediate(12'hffb, isaPkg::f3Slt);
        runImmediate(12'h123, isaPkg::f3Sltu);
        runImmediate(12'hf0f, isaPkg::f3Xor);
        runImmediate(12'h055, isaPkg::f3Or);
        runImmediate(12'h8a3, isaPkg::f3And);
        // Shifts keep only the 5-bit shamt
        runInstr(encodeI({isaPkg::funct7Base, 5'd31}, isaPkg::f3Sll, isaPkg::opImm),
                 datapathPkg::aluSll, datapathPkg::bSelImm, 32'd31, 1'b0,
                 datapathPkg::aluAdd, 1'b0, 1'b1);
        runInstr(encodeI({isaPkg::funct7Base, 5'd7}, isaPkg::f3SrlSra, isaPkg::opImm),
                 datapathPkg::aluSrl, datapathPkg::bSelImm, 32'd7, 1'b0,
                 datapathPkg::aluAdd, 1'b0, 1'b1);
        runInstr(encodeI({isaPkg::funct7Alt, 5'd19}, isaPkg::f3SrlSra, isaPkg::opImm),
                 datapathPkg::aluSra, datapathPkg::bSelImm, 32'd19, 1'b0,
                 datapathPkg::aluAdd, 1'b0, 1'b1);
    endtask

    task automatic testLoads();
        runLoad(isaPkg::f3Lb,  datapathPkg::aluByteSigned,   1'b1);
        runLoad(isaPkg::f3Lh,  datapathPkg::aluHalfSigned,   1'b1);
        runLoad(isaPkg::f3Lw,  datapathPkg::aluAdd,          1'b0);  // No second pass
        runLoad(isaPkg::f3Lbu, datapathPkg::aluByteUnsigned, 1'b1);
        runLoad(isaPkg::f3Lhu, datapathPkg::aluHalfUnsigned, 1'b1);
    endtask

    task automatic testBackPressureIllegal();
        delayFloor = 4;  // Long waits on every handshake
        runRegister(isaPkg::funct7Alt, isaPkg::f3AddSub, datapathPkg::aluSub);
        runLoad(isaPkg::f3Lh, datapathPkg::aluHalfSigned, 1'b1);
        delayFloor = 0;
        runIllegal(encodeI(12'h010, 3'b010, 7'd35));              // Store word
        runIllegal({20'h12345, 5'd3, 7'd55});                     // lui
        runIllegal(encodeR(7'b0000001, isaPkg::f3AddSub));        // Unknown funct7
        runIllegal(encodeI(12'h004, 3'b011, isaPkg::opLoad));     // Load funct3 3
        runIllegal(encodeI(12'h004, 3'b110, isaPkg::opLoad));     // Load funct3 6
        runIllegal(encodeI({7'b0000001, 5'd3}, isaPkg::f3Sll, isaPkg::opImm));
        runImmediate(12'h001, isaPkg::f3AddSub);  // Still retires after illegal words
    endtask

    initial
    begin
        seedState   = $urandom(32'h8093_d088);  // Seed once for the run
        reset       = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        pcIn        = '0;
        dataReady   = 1'b0;
        aluComplete = 1'b0;
        memAck      = 1'b0;
        delayFloor  = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        testResetState();
        testRegisterOps();
        testImmediateOps();
        testLoads();
        testBackPressureIllegal();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
